/* hw/lcd_bus_if.sv */
// lcd panel bus stage: 8080-style strobe timing per beat and read data capture
`timescale 1ns/1ps
`default_nettype none

`include "lcd_macros.svh"

module lcd_bus_if (
    input  logic                   pclk,
    input  logic                   rst_n,
    // from decoder
    input  logic                   beat_start_i,
    input  lcd_bus_pkg::lcd_beat_t beat_i,
    output logic                   beat_done_o,
    // read data
    output lcd_bus_pkg::bus_word_t rdata_o,
    output logic                   rdata_valid_o,
    // panel pins
    output logic                   lcd_cs_n_o,
    output logic                   lcd_rs_o,
    output logic                   lcd_wr_n_o,
    output logic                   lcd_rd_n_o,
    output lcd_bus_pkg::bus_word_t lcd_db_o,
    output logic                   lcd_db_oe_o,
    input  lcd_bus_pkg::bus_word_t lcd_db_i
);
    import lcd_bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        STROBE,
        RECOVER
    } phase_t;

    phase_t     phase_q;
    logic [3:0] cnt_q;
    lcd_beat_t  beat_q;
    logic       strobe_last;
    logic       recover_last;

    assign strobe_last  = (phase_q == STROBE) && (cnt_q == 4'(`LCD_STROBE_CYCLES - 1));
    assign recover_last = (phase_q == RECOVER) && (cnt_q == 4'(`LCD_RECOVER_CYCLES - 1));

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            phase_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (phase_q)
                IDLE: begin
                    if (beat_start_i) begin
                        phase_q <= STROBE;
                        cnt_q   <= '0;
                    end
                end
                STROBE: begin
                    if (strobe_last) begin
                        phase_q <= RECOVER;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 4'd1;
                    end
                end
                RECOVER: begin
                    if (recover_last) begin
                        phase_q <= IDLE;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 4'd1;
                    end
                end
                default: phase_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (phase_q == IDLE && beat_start_i) begin
            beat_q <= beat_i;
        end
        // panel data is settled by the end of the low phase
        if (strobe_last && beat_q.rd) begin
            rdata_o <= lcd_db_i;
        end
    end

    assign beat_done_o   = recover_last;
    assign rdata_valid_o = recover_last && beat_q.rd;

    // chip select spans both phases of the beat
    assign lcd_cs_n_o  = (phase_q == IDLE);
    assign lcd_rs_o    = beat_q.rs;
    assign lcd_wr_n_o  = !((phase_q == STROBE) && !beat_q.rd);
    assign lcd_rd_n_o  = !((phase_q == STROBE) && beat_q.rd);
    assign lcd_db_o    = beat_q.word;
    assign lcd_db_oe_o = (phase_q != IDLE) && !beat_q.rd;

endmodule

`default_nettype wire

/* hw/lcd_bus_pkg.sv */
// panel bus types for the lcd controller: bus word and decoder-to-bus beat
`default_nettype none

package lcd_bus_pkg;

    // 16-bit parallel data bus of the panel
    typedef logic [15:0] bus_word_t;

    // one panel access
    // rd 1 reads the panel, rd 0 writes word
    // rs 0 marks an instruction, rs 1 a data beat
    typedef struct packed {
        logic      rd;
        logic      rs;
        bus_word_t word;
    } lcd_beat_t;

endpackage

`default_nettype wire

/* hw/lcd_cmd_pkg.sv */
// host command types for the lcd controller: command word fields and register bus
`default_nettype none

package lcd_cmd_pkg;

    // command word fields
    typedef logic [7:0]  opcode_t;
    typedef logic [7:0]  func_t;
    typedef logic [15:0] param_t;

    // host command word, opcode in the top byte
    typedef struct packed {
        opcode_t opcode;
        func_t   func;
        param_t  param;
    } lcd_cmd_t;

    // number of colour data beats in one fill
    typedef logic [31:0] pixel_count_t;

    // host register bus
    typedef logic [31:0] host_addr_t;
    typedef logic [31:0] host_data_t;

endpackage

`default_nettype wire

/* hw/lcd_id.sv */
// lcd instruction decoder that expands one host command into its panel beat sequence
`timescale 1ns/1ps
`default_nettype none

`include "lcd_macros.svh"

module lcd_id (
    input  logic                      pclk,
    input  logic                      rst_n,
    // from register front end
    input  logic                      cmd_valid_i,
    input  lcd_cmd_pkg::lcd_cmd_t     cmd_i,
    input  lcd_cmd_pkg::pixel_count_t pix_count_i,
    output logic                      cmd_ready_o,
    // to bus stage
    output logic                      beat_start_o,
    output lcd_bus_pkg::lcd_beat_t    beat_o,
    input  logic                      beat_done_i
);
    import lcd_cmd_pkg::*;
    import lcd_bus_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        ID_INST,
        ID_READ,
        SCAN_INST,
        SCAN_DATA,
        COORD_INST_HI,
        COORD_DATA_HI,
        COORD_INST_LO,
        COORD_DATA_LO,
        COLOR_INST,
        COLOR_DATA,
        RCOLOR_INST,
        RCOLOR_READ
    } state_t;

    state_t       state_q;
    state_t       state_d;
    lcd_cmd_t     cmd_q;
    pixel_count_t pix_q;
    pixel_count_t fill_cnt;
    pixel_count_t fill_next;
    logic         coord_fn_ok;
    logic         launch;

    assign cmd_ready_o = (state_q == IDLE);
    assign fill_next   = fill_cnt + pixel_count_t'(1);
    assign coord_fn_ok = (cmd_i.func == `LCD_FN_START) || (cmd_i.func == `LCD_FN_END);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cmd_valid_i) begin
                    case (cmd_i.opcode)
                        `LCD_OP_ID1, `LCD_OP_ID2, `LCD_OP_ID3: state_d = ID_INST;
                        `LCD_OP_SCAN:   state_d = SCAN_INST;
                        `LCD_OP_COL, `LCD_OP_PAGE: begin
                            // bad function code leaves us idle
                            if (coord_fn_ok) begin
                                state_d = COORD_INST_HI;
                            end
                        end
                        `LCD_OP_WCOLOR: state_d = COLOR_INST;
                        `LCD_OP_RCOLOR: state_d = RCOLOR_INST;
                        default:        state_d = IDLE;
                    endcase
                end
            end
            ID_INST:       if (beat_done_i) state_d = ID_READ;
            ID_READ:       if (beat_done_i) state_d = IDLE;
            SCAN_INST:     if (beat_done_i) state_d = SCAN_DATA;
            SCAN_DATA:     if (beat_done_i) state_d = IDLE;
            COORD_INST_HI: if (beat_done_i) state_d = COORD_DATA_HI;
            COORD_DATA_HI: if (beat_done_i) state_d = COORD_INST_LO;
            COORD_INST_LO: if (beat_done_i) state_d = COORD_DATA_LO;
            COORD_DATA_LO: if (beat_done_i) state_d = IDLE;
            COLOR_INST: begin
                if (beat_done_i) begin
                    state_d = (pix_q == '0) ? IDLE : COLOR_DATA;
                end
            end
            COLOR_DATA: begin
                if (beat_done_i && fill_next == pix_q) begin
                    state_d = IDLE;
                end
            end
            RCOLOR_INST:   if (beat_done_i) state_d = RCOLOR_READ;
            RCOLOR_READ:   if (beat_done_i) state_d = IDLE;
            default:       state_d = IDLE;
        endcase
    end

    // new beat after a command arrives or after each done, unless finished
    assign launch = (state_d != IDLE) && ((state_q == IDLE) || beat_done_i);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            beat_start_o <= 1'b0;
            fill_cnt     <= '0;
        end else begin
            state_q      <= state_d;
            beat_start_o <= launch;
            if (state_q == COLOR_INST) begin
                fill_cnt <= '0;
            end else if (state_q == COLOR_DATA && beat_done_i) begin
                fill_cnt <= fill_next;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (state_q == IDLE && cmd_valid_i) begin
            cmd_q <= cmd_i;
            pix_q <= pix_count_i;
        end
    end

    // beat word follows the current state, so it holds until done
    always_comb begin
        beat_o = '{rd: 1'b0, rs: 1'b0, word: bus_word_t'({cmd_q.opcode, 8'h00})};
        case (state_q)
            ID_READ, RCOLOR_READ: begin
                beat_o = '{rd: 1'b1, rs: 1'b1, word: '0};
            end
            SCAN_DATA, COLOR_DATA: begin
                beat_o.rs   = 1'b1;
                beat_o.word = cmd_q.param;
            end
            COORD_INST_HI: begin
                beat_o.word = {cmd_q.opcode, cmd_q.func};
            end
            COORD_DATA_HI: begin
                beat_o.rs   = 1'b1;
                beat_o.word = {8'h00, cmd_q.param[15:8]};
            end
            // low half uses the odd function code
            COORD_INST_LO: begin
                beat_o.word = {cmd_q.opcode, cmd_q.func[7:1], 1'b1};
            end
            COORD_DATA_LO: begin
                beat_o.rs   = 1'b1;
                beat_o.word = {8'h00, cmd_q.param[7:0]};
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/lcd_reg_front.sv */
// lcd host register front end: size register, command issue and dropped-write flag
`timescale 1ns/1ps
`default_nettype none

`include "lcd_macros.svh"

module lcd_reg_front (
    input  logic                      pclk,
    input  logic                      rst_n,
    // host register port
    input  logic                      host_we_i,
    input  lcd_cmd_pkg::host_addr_t   host_addr_i,
    input  lcd_cmd_pkg::host_data_t   host_wdata_i,
    // decoder side
    input  logic                      cmd_ready_i,
    output logic                      cmd_valid_o,
    output lcd_cmd_pkg::lcd_cmd_t     cmd_o,
    output lcd_cmd_pkg::pixel_count_t pix_count_o,
    // status
    output logic                      ready_o,
    output logic                      drop_o
);
    import lcd_cmd_pkg::*;

    logic cmd_wr;
    logic size_wr;
    logic accept;

    assign cmd_wr  = host_we_i && (host_addr_i == `LCD_REG_CMD);
    assign size_wr = host_we_i && (host_addr_i == `LCD_REG_SIZE);

    // busy as soon as a command is in flight to the decoder
    assign ready_o = cmd_ready_i && !cmd_valid_o;
    assign accept  = cmd_wr && ready_o;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            cmd_valid_o <= 1'b0;
            drop_o      <= 1'b0;
            pix_count_o <= '0;
        end else begin
            cmd_valid_o <= accept;
            // sticky until reset
            if (cmd_wr && !ready_o) begin
                drop_o <= 1'b1;
            end
            if (size_wr) begin
                pix_count_o <= pixel_count_t'(host_wdata_i);
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (accept) begin
            cmd_o <= lcd_cmd_t'(host_wdata_i);
        end
    end

endmodule

`default_nettype wire

/* hw/lcd_top.sv */
// lcd controller top: host register front end, instruction decoder and panel bus stage
`timescale 1ns/1ps
`default_nettype none

module lcd_top (
    input  logic                    pclk,
    input  logic                    rst_n,
    // host port
    input  logic                    host_we_i,
    input  lcd_cmd_pkg::host_addr_t host_addr_i,
    input  lcd_cmd_pkg::host_data_t host_wdata_i,
    output logic                    ready_o,
    output logic                    drop_o,
    output lcd_bus_pkg::bus_word_t  rdata_o,
    output logic                    rdata_valid_o,
    // panel pins
    output logic                    lcd_cs_n_o,
    output logic                    lcd_rs_o,
    output logic                    lcd_wr_n_o,
    output logic                    lcd_rd_n_o,
    output lcd_bus_pkg::bus_word_t  lcd_db_o,
    output logic                    lcd_db_oe_o,
    input  lcd_bus_pkg::bus_word_t  lcd_db_i
);
    import lcd_cmd_pkg::*;
    import lcd_bus_pkg::*;

    logic         cmd_valid;
    lcd_cmd_t     cmd;
    pixel_count_t pix_count;
    logic         cmd_ready;
    logic         beat_start;
    lcd_beat_t    beat;
    logic         beat_done;

    lcd_reg_front u_reg_front (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .cmd_ready_i  (cmd_ready),
        .cmd_valid_o  (cmd_valid),
        .cmd_o        (cmd),
        .pix_count_o  (pix_count),
        .ready_o      (ready_o),
        .drop_o       (drop_o)
    );

    lcd_id u_id (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .cmd_valid_i  (cmd_valid),
        .cmd_i        (cmd),
        .pix_count_i  (pix_count),
        .cmd_ready_o  (cmd_ready),
        .beat_start_o (beat_start),
        .beat_o       (beat),
        .beat_done_i  (beat_done)
    );

    lcd_bus_if u_bus_if (
        .pclk          (pclk),
        .rst_n         (rst_n),
        .beat_start_i  (beat_start),
        .beat_i        (beat),
        .beat_done_o   (beat_done),
        .rdata_o       (rdata_o),
        .rdata_valid_o (rdata_valid_o),
        .lcd_cs_n_o    (lcd_cs_n_o),
        .lcd_rs_o      (lcd_rs_o),
        .lcd_wr_n_o    (lcd_wr_n_o),
        .lcd_rd_n_o    (lcd_rd_n_o),
        .lcd_db_o      (lcd_db_o),
        .lcd_db_oe_o   (lcd_db_oe_o),
        .lcd_db_i      (lcd_db_i)
    );

endmodule

`default_nettype wire

/* include/lcd_macros.svh */
// lcd controller constants for panel opcodes, host register map and bus phase timing
`ifndef LCD_MACROS_SVH
`define LCD_MACROS_SVH

// panel opcodes
`define LCD_OP_ID1      8'hDA
`define LCD_OP_ID2      8'hDB
`define LCD_OP_ID3      8'hDC
`define LCD_OP_SCAN     8'h36
`define LCD_OP_COL      8'h2A
`define LCD_OP_PAGE     8'h2B
`define LCD_OP_WCOLOR   8'h2C
`define LCD_OP_RCOLOR   8'h2E

// coordinate select for column/page commands
`define LCD_FN_START    8'h00
`define LCD_FN_END      8'h02

// host register offsets
`define LCD_REG_CMD     32'h0000_0000
`define LCD_REG_SIZE    32'h0000_0004

// beat phase lengths in pclk cycles
`define LCD_STROBE_CYCLES  2
`define LCD_RECOVER_CYCLES 2

`endif

/* project.f */
+incdir+include
hw/lcd_cmd_pkg.sv
hw/lcd_bus_pkg.sv
hw/lcd_reg_front.sv
hw/lcd_id.sv
hw/lcd_bus_if.sv
hw/lcd_top.sv
tb/lcd_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the lcd controller testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module lcd_tb -f project.f -o lcd_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lcd_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$log"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

/* tb/lcd_tb.sv */
// self-checking testbench for the lcd controller driven by command vectors
`timescale 1ns/1ps
`default_nettype none

`include "lcd_macros.svh"

module lcd_tb;
    import lcd_cmd_pkg::*;
    import lcd_bus_pkg::*;

    logic       pclk = 1'b0;
    logic       rst_n;
    logic       host_we;
    host_addr_t host_addr;
    host_data_t host_wdata;
    logic       ready;
    logic       drop;
    bus_word_t  rdata;
    logic       rdata_valid;
    logic       lcd_cs_n;
    logic       lcd_rs;
    logic       lcd_wr_n;
    logic       lcd_rd_n;
    bus_word_t  lcd_db_o;
    logic       lcd_db_oe;
    bus_word_t  lcd_db_i;

    // loaded vectors
    int           kinds[$];
    lcd_cmd_t     cmds[$];
    pixel_count_t counts[$];
    bus_word_t    read_vals[$];

    lcd_beat_t exp_q[$];
    lcd_beat_t obs_q[$];
    int        obs_rd = 0;
    bus_word_t panel_value = '0;
    logic      exp_drop = 1'b0;
    int        seed = 59;
    int        errors = 0;
    int        mon_errors = 0;
    int        cycles = 0;
    int        cycle_limit = 200;

    // bus monitor state
    int        beat_len = 0;
    int        strobe_len = 0;
    logic      prev_wr_n = 1'b1;
    logic      prev_rd_n = 1'b1;
    int        rd_pulses = 0;
    bus_word_t rd_last = '0;

    always #10 pclk = ~pclk;

    lcd_top UUT (
        .pclk          (pclk),
        .rst_n         (rst_n),
        .host_we_i     (host_we),
        .host_addr_i   (host_addr),
        .host_wdata_i  (host_wdata),
        .ready_o       (ready),
        .drop_o        (drop),
        .rdata_o       (rdata),
        .rdata_valid_o (rdata_valid),
        .lcd_cs_n_o    (lcd_cs_n),
        .lcd_rs_o      (lcd_rs),
        .lcd_wr_n_o    (lcd_wr_n),
        .lcd_rd_n_o    (lcd_rd_n),
        .lcd_db_o      (lcd_db_o),
        .lcd_db_oe_o   (lcd_db_oe),
        .lcd_db_i      (lcd_db_i)
    );

    // panel answers while rd_n is low
    assign lcd_db_i = (lcd_rd_n === 1'b0) ? panel_value : '0;

    always @(posedge pclk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout, run still busy after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    function automatic lcd_beat_t make_beat(input logic rd, input logic rs, input bus_word_t word);
        lcd_beat_t b;
        b.rd   = rd;
        b.rs   = rs;
        b.word = word;
        return b;
    endfunction

    // panel pin rules, beat capture and read data pulses
    always @(negedge pclk) begin
        if (rst_n === 1'b1) begin
            if (lcd_cs_n && (!lcd_wr_n || !lcd_rd_n)) begin
                $display("strobe low while chip select is high at %0t", $time);
                mon_errors++;
            end
            if (!lcd_rd_n && lcd_db_oe) begin
                $display("data bus driven during a read strobe at %0t", $time);
                mon_errors++;
            end
            if (!lcd_wr_n && !lcd_db_oe) begin
                $display("data bus not driven during a write strobe at %0t", $time);
                mon_errors++;
            end
            if (!lcd_cs_n) begin
                beat_len++;
                if (!lcd_wr_n || !lcd_rd_n) begin
                    strobe_len++;
                end
            end else if (beat_len != 0) begin
                if (beat_len != `LCD_STROBE_CYCLES + `LCD_RECOVER_CYCLES ||
                    strobe_len != `LCD_STROBE_CYCLES) begin
                    $display("CHECK FAILED beat timing at %0t: expected %0d/%0d, actual %0d/%0d",
                             $time, `LCD_STROBE_CYCLES + `LCD_RECOVER_CYCLES,
                             `LCD_STROBE_CYCLES, beat_len, strobe_len);
                    mon_errors++;
                end
                beat_len   = 0;
                strobe_len = 0;
            end
            // strobe release ends one access
            if (!prev_wr_n && lcd_wr_n) begin
                obs_q.push_back(make_beat(1'b0, lcd_rs, lcd_db_o));
            end
            if (!prev_rd_n && lcd_rd_n) begin
                obs_q.push_back(make_beat(1'b1, lcd_rs, 16'h0000));
            end
            prev_wr_n = lcd_wr_n;
            prev_rd_n = lcd_rd_n;
            if (rdata_valid) begin
                rd_pulses++;
                rd_last = rdata;
            end
        end
    end

    function automatic void build_expected(input lcd_cmd_t cmd, input pixel_count_t count);
        func_t lo_fn;
        lo_fn = (cmd.func == `LCD_FN_START) ? 8'h01 : 8'h03;
        case (cmd.opcode)
            `LCD_OP_ID1, `LCD_OP_ID2, `LCD_OP_ID3, `LCD_OP_RCOLOR: begin
                exp_q.push_back(make_beat(1'b0, 1'b0, {cmd.opcode, 8'h00}));
                exp_q.push_back(make_beat(1'b1, 1'b1, 16'h0000));
            end
            `LCD_OP_SCAN: begin
                exp_q.push_back(make_beat(1'b0, 1'b0, {cmd.opcode, 8'h00}));
                exp_q.push_back(make_beat(1'b0, 1'b1, cmd.param));
            end
            `LCD_OP_COL, `LCD_OP_PAGE: begin
                if (cmd.func == `LCD_FN_START || cmd.func == `LCD_FN_END) begin
                    exp_q.push_back(make_beat(1'b0, 1'b0, {cmd.opcode, cmd.func}));
                    exp_q.push_back(make_beat(1'b0, 1'b1, {8'h00, cmd.param[15:8]}));
                    exp_q.push_back(make_beat(1'b0, 1'b0, {cmd.opcode, lo_fn}));
                    exp_q.push_back(make_beat(1'b0, 1'b1, {8'h00, cmd.param[7:0]}));
                end
            end
            `LCD_OP_WCOLOR: begin
                exp_q.push_back(make_beat(1'b0, 1'b0, {cmd.opcode, 8'h00}));
                for (pixel_count_t i = 0; i < count; i++) begin
                    exp_q.push_back(make_beat(1'b0, 1'b1, cmd.param));
                end
            end
            default: begin
            end
        endcase
    endfunction

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_int(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_beats(input string name);
        int n_obs;
        n_obs = obs_q.size() - obs_rd;
        if (n_obs != exp_q.size()) begin
            $display("CHECK FAILED %s beat count: expected %0d, actual %0d",
                     name, exp_q.size(), n_obs);
            errors++;
        end else begin
            for (int i = 0; i < n_obs; i++) begin
                if (obs_q[obs_rd + i] != exp_q[i]) begin
                    $display("CHECK FAILED %s beat %0d: expected %h, actual %h",
                             name, i, exp_q[i], obs_q[obs_rd + i]);
                    errors++;
                end
            end
        end
        obs_rd = obs_q.size();
        exp_q.delete();
    endtask

    task automatic write_reg(input host_addr_t addr, input host_data_t data);
        @(posedge pclk);
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        @(posedge pclk);
        host_we    <= 1'b0;
    endtask

    task automatic wait_ready();
        do begin
            @(negedge pclk);
        end while (ready !== 1'b1);
    endtask

    initial begin
        int          fd;
        int          nread;
        int          total_beats;
        int          pulses_before;
        logic        is_read;
        string       line;
        string       name;
        logic [31:0] f_kind;
        logic [31:0] f_cmd;
        logic [31:0] f_count;
        logic [31:0] f_read;

        rst_n       = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        total_beats = 0;

        fd = $fopen("tb/lcd_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/lcd_vectors.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#") begin
                    nread = $sscanf(line, "%h %h %h %h", f_kind, f_cmd, f_count, f_read);
                    if (nread == 4) begin
                        // kind 2 draws its own fill length
                        if (f_kind == 32'd2) begin
                            f_count = $unsigned($random(seed)) % 16;
                        end
                        kinds.push_back(int'(f_kind));
                        cmds.push_back(lcd_cmd_t'(f_cmd));
                        counts.push_back(f_count);
                        read_vals.push_back(f_read[15:0]);
                        build_expected(lcd_cmd_t'(f_cmd), f_count);
                        total_beats += exp_q.size();
                        exp_q.delete();
                    end
                end
            end
            $fclose(fd);
        end
        if (cmds.size() == 0) begin
            $display("no command vectors were read");
            errors++;
        end
        cycle_limit = 4 * total_beats * 2 + 200;

        repeat (4) @(posedge pclk);
        rst_n <= 1'b1;
        @(negedge pclk);
        check_bit("reset cs_n", 1'b1, lcd_cs_n);
        check_bit("reset wr_n", 1'b1, lcd_wr_n);
        check_bit("reset rd_n", 1'b1, lcd_rd_n);
        check_bit("reset db_oe", 1'b0, lcd_db_oe);
        check_bit("reset ready", 1'b1, ready);
        check_bit("reset drop", 1'b0, drop);
        check_bit("reset rdata_valid", 1'b0, rdata_valid);

        for (int v = 0; v < cmds.size(); v++) begin
            name = $sformatf("vector %0d opcode %h", v, cmds[v].opcode);
            build_expected(cmds[v], counts[v]);
            is_read = cmds[v].opcode inside {`LCD_OP_ID1, `LCD_OP_ID2, `LCD_OP_ID3,
                                             `LCD_OP_RCOLOR};
            panel_value   = read_vals[v];
            pulses_before = rd_pulses;
            write_reg(`LCD_REG_SIZE, counts[v]);
            write_reg(`LCD_REG_CMD, host_data_t'(cmds[v]));
            if (kinds[v] == 1) begin
                // lands while busy and must not run
                write_reg(`LCD_REG_CMD, {`LCD_OP_ID1, 24'h000000});
                exp_drop = 1'b1;
            end
            wait_ready();
            check_beats(name);
            check_int({name, " read pulses"}, is_read ? 1 : 0, rd_pulses - pulses_before);
            if (is_read) begin
                check_int({name, " read data"}, int'(read_vals[v]), int'(rd_last));
            end
            check_bit({name, " drop flag"}, exp_drop, drop);
        end

        repeat (4) @(negedge pclk);
        $display("error count: %0d in checks, %0d on the panel bus", errors, mon_errors);
        if (errors + mon_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/lcd_vectors.txt */
# kind cmd_word pixel_count read_value, all fields hex
# kind 0 plain command, 1 extra command write while busy, 2 fill with random count
0 DA000000 00000000 5A11
0 DB000000 00000000 0022
0 DC0000FF 00000000 3303
0 36000068 00000000 0000
0 2A000140 00000000 0000
0 2A0201DF 00000000 0000
0 2B000012 00000000 0000
0 2B02013F 00000000 0000
0 2C00F800 00000005 0000
0 2C001234 00000000 0000
0 2E000000 00000000 C3A5
0 77000000 00000000 0000
0 2A01ABCD 00000000 0000
0 2B030010 00000000 0000
0 00000000 00000000 0000
1 2C0007E0 00000003 0000
0 36000008 00000000 0000
2 2C00001F 00000000 0000
2 2C00FFFF 00000000 0000
2 2C00AAAA 00000000 0000
0 2E000000 00000000 1234
